// ==== compile.f ====
verilog/rename_pkg.sv
verilog/free_list.sv
verilog/rename_map.sv
verilog/instr_queue.sv
verilog/rename_stage.sv
verilog/rename_unit.sv
tb/rename_unit_sva.sv
tb/tb_rename_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the rename unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_rename_unit -f compile.f -o sim_rename_unit

# Keep running after an assertion error so the testbench prints its result line
status=0
output=$(./obj_dir/sim_rename_unit +verilator+error+limit+1000 2>&1) || status=$?
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'Result: PASSED'; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed (simulator exit status $status)"
exit 1

// ==== tb/rename_unit_sva.sv ====
// Concurrent checks on the rename unit ports and their bind into rename_unit

`timescale 1ns/1ps

module rename_unit_sva import rename_pkg::*; #(
	parameter int NUM_ARCH_REGS = 32,
	parameter int NUM_PHYS_REGS = 64
) (
	input logic                             clk,
	input logic                             rst_n,
	input logic                             dec_ready,
	input logic                             iq_valid,
	input logic                             iq_ready,
	input alu_op_e                          iq_alu_op,
	input mem_action_e                      iq_mem_action,
	input logic [IMM_WIDTH-1:0]             iq_immediate,
	input logic [$clog2(NUM_PHYS_REGS)-1:0] iq_rs_phys,
	input logic [$clog2(NUM_PHYS_REGS)-1:0] iq_rt_phys,
	input logic [$clog2(NUM_PHYS_REGS)-1:0] iq_rd_phys,
	input logic [$clog2(NUM_PHYS_REGS)-1:0] iq_old_rd_phys,
	input logic                             iq_has_rd
);

	int unsigned              fail_count = 0;
	logic [NUM_PHYS_REGS-1:0] live;  // Tags held by the retired mapping
	logic                     retire;

	assign retire = iq_valid && iq_ready && iq_has_rd;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_PHYS_REGS; i++)
				live[i] <= (i < NUM_ARCH_REGS);  // Identity map after reset
		end else if (retire) begin
			live[iq_old_rd_phys] <= 1'b0;
			live[iq_rd_phys]     <= 1'b1;
		end
	end

	// ========================================
	// Port rules
	// ========================================
	a_reset_state: assert property (@(posedge clk) !rst_n |-> !iq_valid && dec_ready)
		else begin
			$error("Queue output valid or decoder stalled during reset");
			fail_count++;
		end

	// Head entry holds while the consumer stalls
	a_stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
		iq_valid && !iq_ready |=> iq_valid && $stable(iq_alu_op) && $stable(iq_mem_action)
			&& $stable(iq_immediate) && $stable(iq_rs_phys) && $stable(iq_rt_phys)
			&& $stable(iq_rd_phys) && $stable(iq_old_rd_phys) && $stable(iq_has_rd))
		else begin
			$error("Queue head changed while stalled");
			fail_count++;
		end

	a_rd_not_zero: assert property (@(posedge clk) disable iff (!rst_n)
		retire |-> iq_rd_phys != '0)  // Physical 0 belongs to register 0
		else begin
			$error("Destination renamed to physical register 0");
			fail_count++;
		end

	// A destination tag must have been free, the displaced one live
	a_tag_unique: assert property (@(posedge clk) disable iff (!rst_n)
		retire |-> !live[iq_rd_phys] && live[iq_old_rd_phys])
		else begin
			$error("Physical tag handed out while still live");
			fail_count++;
		end

endmodule

bind rename_unit rename_unit_sva #(
	.NUM_ARCH_REGS(NUM_ARCH_REGS),
	.NUM_PHYS_REGS(NUM_PHYS_REGS)
) u_sva (
	.clk, .rst_n, .dec_ready, .iq_valid, .iq_ready, .iq_alu_op, .iq_mem_action,
	.iq_immediate, .iq_rs_phys, .iq_rt_phys, .iq_rd_phys, .iq_old_rd_phys, .iq_has_rd
);

// ==== tb/tb_rename_unit.sv ====
// Testbench for rename_unit: clock, reset, stimulus, reference map model, watchdog, result line

`timescale 1ns/1ps

module tb_rename_unit import rename_pkg::*; ();

	localparam int NUM_ARCH_REGS   = 32;
	localparam int NUM_PHYS_REGS   = 40;  // Leaves 8 free tags
	localparam int IQ_SIZE         = 16;
	localparam int ARCH_W          = $clog2(NUM_ARCH_REGS);
	localparam int TAG_W           = $clog2(NUM_PHYS_REGS);
	localparam int CLK_PERIOD      = 4;
	localparam int RESET_CYCLES    = 16;
	localparam int NUM_RANDOM      = 200;
	localparam int WAIT_LIMIT      = 64;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 300 + 8 * NUM_RANDOM;

	typedef struct packed {
		alu_op_e              alu_op;
		mem_action_e          mem_action;
		logic [IMM_WIDTH-1:0] immediate;
		logic [TAG_W-1:0]     rs_phys, rt_phys, rd_phys, old_rd_phys;
		logic                 has_rd;
	} entry_t;

	logic                 clk, rst_n;
	logic                 dec_valid, dec_ready, uses_rs, uses_rt, uses_rw;
	alu_op_e              dec_alu_op, iq_alu_op;
	mem_action_e          dec_mem_action, iq_mem_action;
	logic [IMM_WIDTH-1:0] dec_immediate, iq_immediate;
	logic [ARCH_W-1:0]    rs_addr, rt_addr, rw_addr;
	logic                 iq_valid, iq_ready, iq_has_rd;
	logic [TAG_W-1:0]     iq_rs_phys, iq_rt_phys, iq_rd_phys, iq_old_rd_phys;

	// Reference model
	logic [TAG_W-1:0] ref_map [NUM_ARCH_REGS];
	logic [TAG_W-1:0] ref_free [$];
	entry_t           exp_q [$];
	int               errors = 0;
	bit               ready_random = 1'b0;  // Else iq_ready high
	int               ready_hold = 0;       // Cycles of forced iq_ready low

	rename_unit #(
		.NUM_ARCH_REGS(NUM_ARCH_REGS),
		.NUM_PHYS_REGS(NUM_PHYS_REGS),
		.INSTR_QUEUE_SIZE(IQ_SIZE)
	) UUT (.*);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected)
		else begin
			$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, expected);
			errors++;
		end
	endtask

	task automatic start_cycle(input logic valid);
		@(negedge clk);
		dec_valid = valid;
		if (ready_hold > 0) begin
			iq_ready = 1'b0;
			ready_hold--;
		end else
			iq_ready = ready_random ? 1'($urandom_range(0, 1)) : 1'b1;
	endtask

	// ========================================
	// Mirror of the coming rising edge
	// ========================================
	task automatic sample_cycle(output logic acc);
		entry_t head;
		entry_t e;
		logic   needs;
		logic   popped;
		#1;
		needs = uses_rw && (rw_addr != '0);
		check_value("dec_ready", 32'(dec_ready),
			32'((exp_q.size() < IQ_SIZE) && (!needs || (ref_free.size() != 0))));
		check_value("iq_valid", 32'(iq_valid), 32'(exp_q.size() != 0));
		acc    = dec_valid && dec_ready;
		popped = iq_valid && iq_ready && (exp_q.size() != 0);
		if (popped) begin
			head = exp_q.pop_front();
			check_value("iq_alu_op", 32'(iq_alu_op), 32'(head.alu_op));
			check_value("iq_mem_action", 32'(iq_mem_action), 32'(head.mem_action));
			check_value("iq_immediate", iq_immediate, head.immediate);
			check_value("iq_rs_phys", 32'(iq_rs_phys), 32'(head.rs_phys));
			check_value("iq_rt_phys", 32'(iq_rt_phys), 32'(head.rt_phys));
			check_value("iq_rd_phys", 32'(iq_rd_phys), 32'(head.rd_phys));
			check_value("iq_old_rd_phys", 32'(iq_old_rd_phys), 32'(head.old_rd_phys));
			check_value("iq_has_rd", 32'(iq_has_rd), 32'(head.has_rd));
		end
		if (acc) begin
			e = '0;
			e.alu_op     = dec_alu_op;
			e.mem_action = dec_mem_action;
			e.immediate  = dec_immediate;
			e.rs_phys    = uses_rs ? ref_map[rs_addr] : '0;  // Unused source reads tag 0
			e.rt_phys    = uses_rt ? ref_map[rt_addr] : '0;
			if (needs && (ref_free.size() != 0)) begin
				e.has_rd      = 1'b1;
				e.rd_phys     = ref_free.pop_front();
				e.old_rd_phys = ref_map[rw_addr];
				ref_map[rw_addr] = e.rd_phys;
			end
			exp_q.push_back(e);
		end
		if (popped && head.has_rd)
			ref_free.push_back(head.old_rd_phys);  // Tail of the list, same edge as the pop
	endtask

	task automatic issue(input alu_op_e op, input logic urs, input int rs, input logic urt,
		input int rt, input logic urw, input int rw);
		mem_action_e          mem;
		logic [IMM_WIDTH-1:0] imm;
		logic                 acc;
		int                   waited;
		mem    = mem_action_e'($urandom_range(0, 2));
		imm    = $urandom;
		acc    = 1'b0;
		waited = 0;
		while (!acc && waited < WAIT_LIMIT) begin
			start_cycle(1'b1);
			dec_alu_op     = op;
			dec_mem_action = mem;
			dec_immediate  = imm;
			uses_rs        = urs;
			rs_addr        = ARCH_W'(rs);
			uses_rt        = urt;
			rt_addr        = ARCH_W'(rt);
			uses_rw        = urw;
			rw_addr        = ARCH_W'(rw);
			sample_cycle(acc);
			waited++;
		end
		if (!acc) begin
			$display("Decoder instruction was not accepted within %0d cycles", WAIT_LIMIT);
			errors++;
		end
	endtask

	task automatic issue_random();
		issue(alu_op_e'($urandom_range(0, 8)), 1'($urandom_range(0, 1)), $urandom_range(0, 31),
			1'($urandom_range(0, 1)), $urandom_range(0, 31), 1'($urandom_range(0, 1)),
			$urandom_range(0, 31));
	endtask

	task automatic drain();
		logic acc;
		ready_random = 1'b0;
		while (exp_q.size() != 0) begin
			start_cycle(1'b0);
			sample_cycle(acc);
		end
	endtask

	task automatic report_counts();
		$display("Errors: %0d from the reference model, %0d from assertions",
			errors, UUT.u_sva.fail_count);
	endtask

	// ========================================
	// Stimulus
	// ========================================
	initial begin
		void'($urandom(38166));
		rst_n          = 1'b0;
		dec_valid      = 1'b0;
		dec_alu_op     = ALU_ADD;
		dec_mem_action = MEM_NONE;
		dec_immediate  = '0;
		{uses_rs, uses_rt, uses_rw} = '0;
		{rs_addr, rt_addr, rw_addr} = '0;
		iq_ready       = 1'b0;
		for (int i = 0; i < NUM_ARCH_REGS; i++)
			ref_map[i] = TAG_W'(i);
		for (int i = NUM_ARCH_REGS; i < NUM_PHYS_REGS; i++)
			ref_free.push_back(TAG_W'(i));
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// Fresh tags in order, identity sources and register 0
		issue(ALU_ADD, 1, 3, 1, 4, 1, 5);
		issue(ALU_SUB, 1, 5, 1, 0, 1, 6);
		issue(ALU_OR, 1, 1, 1, 2, 1, 0);
		issue(ALU_PASS_IMM, 0, 9, 0, 9, 1, 7);
		issue(ALU_ADD, 1, 5, 1, 6, 1, 5);
		issue(ALU_XOR, 1, 0, 1, 7, 0, 5);
		drain();

		// Back-pressure fills the queue, then one more waits
		ready_hold = IQ_SIZE + 4;
		repeat (IQ_SIZE + 1) issue(ALU_SLT, 1, $urandom_range(0, 31), 1, 2, 1, 0);
		drain();

		// Exhaust the free list; a non-writing instruction still gets through
		ready_hold = 8 + 1 + 3;
		for (int i = 1; i <= 8; i++)
			issue(ALU_ADD, 1, i + 10, 0, 0, 1, i);
		issue(ALU_SLL, 1, 1, 0, 0, 0, 0);
		for (int i = 9; i <= 13; i++)
			issue(ALU_SRL, 1, i - 1, 1, 5, 1, i);  // Gets recycled tags
		drain();

		ready_random = 1'b1;
		repeat (NUM_RANDOM) issue_random();
		drain();
		repeat (2) start_cycle(1'b0);

		report_counts();
		if (errors == 0 && UUT.u_sva.fail_count == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		report_counts();
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== verilog/free_list.sv ====
// Circular FIFO of free physical register tags with allocate and release

`timescale 1ns/1ps

module free_list #(
	parameter int NUM_ARCH_REGS = 32,
	parameter int NUM_PHYS_REGS = 64
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             alloc,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] alloc_tag,
	input  logic                             release_en,
	input  logic [$clog2(NUM_PHYS_REGS)-1:0] release_tag,
	output logic                             empty
);

	localparam int TAG_W = $clog2(NUM_PHYS_REGS);
	localparam int DEPTH = NUM_PHYS_REGS - NUM_ARCH_REGS;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [TAG_W-1:0] tags [DEPTH];
	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [CNT_W-1:0] count;

	logic do_alloc;
	logic do_release;

	// Pop only from a non-empty list; push only if there is room or a pop frees a slot
	assign do_alloc   = alloc && (count != '0);
	assign do_release = release_en && ((count != CNT_W'(DEPTH)) || do_alloc);

	assign alloc_tag = tags[head];
	assign empty     = (count == '0);

	// ========================================
	// Pointers, count and tag storage
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head  <= '0;
			tail  <= '0;   // List starts full, so tail has wrapped to head
			count <= CNT_W'(DEPTH);
			for (int i = 0; i < DEPTH; i++) begin
				tags[i] <= TAG_W'(NUM_ARCH_REGS + i);
			end
		end else begin
			if (do_alloc) begin
				head <= (head == PTR_W'(DEPTH - 1)) ? '0 : head + 1'b1;
			end
			if (do_release) begin
				tags[tail] <= release_tag;
				tail       <= (tail == PTR_W'(DEPTH - 1)) ? '0 : tail + 1'b1;
			end
			case ({do_alloc, do_release})
				2'b10:   count <= count - 1'b1;
				2'b01:   count <= count + 1'b1;
				default: count <= count;  // Both or neither
			endcase
		end
	end

endmodule

// ==== verilog/instr_queue.sv ====
// Circular FIFO of renamed instructions; pop retires the entry and frees its old tag

`timescale 1ns/1ps

module instr_queue import rename_pkg::*; #(
	parameter int NUM_PHYS_REGS    = 64,
	parameter int INSTR_QUEUE_SIZE = 16
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             push,
	input  alu_op_e                          ent_alu_op,
	input  mem_action_e                      ent_mem_action,
	input  logic [IMM_WIDTH-1:0]             ent_immediate,
	input  logic [$clog2(NUM_PHYS_REGS)-1:0] ent_rs_phys,
	input  logic [$clog2(NUM_PHYS_REGS)-1:0] ent_rt_phys,
	input  logic [$clog2(NUM_PHYS_REGS)-1:0] ent_rd_phys,
	input  logic [$clog2(NUM_PHYS_REGS)-1:0] ent_old_rd_phys,
	input  logic                             ent_has_rd,
	output logic                             full,
	output logic                             iq_valid,
	input  logic                             iq_ready,
	output alu_op_e                          iq_alu_op,
	output mem_action_e                      iq_mem_action,
	output logic [IMM_WIDTH-1:0]             iq_immediate,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] iq_rs_phys,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] iq_rt_phys,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] iq_rd_phys,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] iq_old_rd_phys,
	output logic                             iq_has_rd,
	output logic                             release_en,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] release_tag
);

	localparam int TAG_W = $clog2(NUM_PHYS_REGS);
	localparam int PTR_W = (INSTR_QUEUE_SIZE > 1) ? $clog2(INSTR_QUEUE_SIZE) : 1;
	localparam int CNT_W = $clog2(INSTR_QUEUE_SIZE + 1);

	// Entry storage, one array per field
	alu_op_e              q_alu_op      [INSTR_QUEUE_SIZE];
	mem_action_e          q_mem_action  [INSTR_QUEUE_SIZE];
	logic [IMM_WIDTH-1:0] q_immediate   [INSTR_QUEUE_SIZE];
	logic [TAG_W-1:0]     q_rs_phys     [INSTR_QUEUE_SIZE];
	logic [TAG_W-1:0]     q_rt_phys     [INSTR_QUEUE_SIZE];
	logic [TAG_W-1:0]     q_rd_phys     [INSTR_QUEUE_SIZE];
	logic [TAG_W-1:0]     q_old_rd_phys [INSTR_QUEUE_SIZE];
	logic                 q_has_rd      [INSTR_QUEUE_SIZE];

	logic [PTR_W-1:0] head;
	logic [PTR_W-1:0] tail;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign full     = (count == CNT_W'(INSTR_QUEUE_SIZE));
	assign iq_valid = (count != '0);
	assign do_push  = push && !full;
	assign do_pop   = iq_valid && iq_ready;

	assign iq_alu_op      = q_alu_op[head];
	assign iq_mem_action  = q_mem_action[head];
	assign iq_immediate   = q_immediate[head];
	assign iq_rs_phys     = q_rs_phys[head];
	assign iq_rt_phys     = q_rt_phys[head];
	assign iq_rd_phys     = q_rd_phys[head];
	assign iq_old_rd_phys = q_old_rd_phys[head];
	assign iq_has_rd      = q_has_rd[head];

	// Retirement returns the displaced mapping to the free list
	assign release_en  = do_pop && q_has_rd[head];
	assign release_tag = q_old_rd_phys[head];

	// ========================================
	// Entry write
	// ========================================
	always_ff @(posedge clk) begin
		if (do_push) begin
			q_alu_op[tail]      <= ent_alu_op;
			q_mem_action[tail]  <= ent_mem_action;
			q_immediate[tail]   <= ent_immediate;
			q_rs_phys[tail]     <= ent_rs_phys;
			q_rt_phys[tail]     <= ent_rt_phys;
			q_rd_phys[tail]     <= ent_rd_phys;
			q_old_rd_phys[tail] <= ent_old_rd_phys;
			q_has_rd[tail]      <= ent_has_rd;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head  <= '0;
			tail  <= '0;
			count <= '0;
		end else begin
			if (do_push)
				tail <= (tail == PTR_W'(INSTR_QUEUE_SIZE - 1)) ? '0 : tail + 1'b1;
			if (do_pop)
				head <= (head == PTR_W'(INSTR_QUEUE_SIZE - 1)) ? '0 : head + 1'b1;
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

// ==== verilog/rename_map.sv ====
// Rename map table with two source read ports, old destination read and one write port

`timescale 1ns/1ps

module rename_map #(
	parameter int NUM_ARCH_REGS = 32,
	parameter int NUM_PHYS_REGS = 64
) (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic [$clog2(NUM_ARCH_REGS)-1:0] rs_addr,
	input  logic [$clog2(NUM_ARCH_REGS)-1:0] rt_addr,
	input  logic [$clog2(NUM_ARCH_REGS)-1:0] rw_addr,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] rs_tag,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] rt_tag,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] old_tag,
	input  logic                             map_we,
	input  logic [$clog2(NUM_ARCH_REGS)-1:0] map_waddr,
	input  logic [$clog2(NUM_PHYS_REGS)-1:0] map_wtag
);

	localparam int ARCH_W = $clog2(NUM_ARCH_REGS);
	localparam int TAG_W  = $clog2(NUM_PHYS_REGS);

	logic [TAG_W-1:0] map [NUM_ARCH_REGS];

	// Combinational lookups, same cycle as the request
	assign rs_tag  = map[rs_addr];
	assign rt_tag  = map[rt_addr];
	assign old_tag = map[rw_addr];

	// ========================================
	// Map update
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_ARCH_REGS; i++) begin
				map[i] <= TAG_W'(i);  // Identity mapping
			end
		end else if (map_we && (map_waddr != ARCH_W'(0))) begin
			// Register 0 stays on physical 0
			map[map_waddr] <= map_wtag;
		end
	end

endmodule

// ==== verilog/rename_pkg.sv ====
// Opcode and memory action types shared by the rename stage, instruction queue and top level

package rename_pkg;

	// ========================================
	// ALU opcodes carried with each instruction
	// ========================================
	typedef enum logic [3:0] {
		ALU_ADD      = 4'h0,
		ALU_SUB      = 4'h1,
		ALU_AND      = 4'h2,
		ALU_OR       = 4'h3,
		ALU_XOR      = 4'h4,
		ALU_SLT      = 4'h5,
		ALU_SLL      = 4'h6,
		ALU_SRL      = 4'h7,
		ALU_PASS_IMM = 4'h8  // Result is the immediate itself
	} alu_op_e;

	// ========================================
	// Memory access kind
	// ========================================
	typedef enum logic [1:0] {
		MEM_NONE  = 2'b00,
		MEM_READ  = 2'b01,
		MEM_WRITE = 2'b10
	} mem_action_e;

	// Immediate width of the payload
	localparam int IMM_WIDTH = 32;

endpackage

// ==== verilog/rename_stage.sv ====
// Rename decision logic: accept and stall, destination allocation, map update and entry assembly

`timescale 1ns/1ps

module rename_stage import rename_pkg::*; #(
	parameter int NUM_ARCH_REGS = 32,
	parameter int NUM_PHYS_REGS = 64
) (
	// Decoder side
	input  logic                             dec_valid,
	output logic                             dec_ready,
	input  alu_op_e                          dec_alu_op,
	input  mem_action_e                      dec_mem_action,
	input  logic [IMM_WIDTH-1:0]             dec_immediate,
	input  logic                             uses_rs,
	input  logic                             uses_rt,
	input  logic                             uses_rw,
	input  logic [$clog2(NUM_ARCH_REGS)-1:0] rw_addr,
	// Rename map
	input  logic [$clog2(NUM_PHYS_REGS)-1:0] rs_tag,
	input  logic [$clog2(NUM_PHYS_REGS)-1:0] rt_tag,
	input  logic [$clog2(NUM_PHYS_REGS)-1:0] old_tag,
	output logic                             map_we,
	output logic [$clog2(NUM_ARCH_REGS)-1:0] map_waddr,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] map_wtag,
	// Free list
	input  logic                             empty,
	output logic                             alloc,
	input  logic [$clog2(NUM_PHYS_REGS)-1:0] alloc_tag,
	// Instruction queue
	input  logic                             full,
	output logic                             push,
	output alu_op_e                          ent_alu_op,
	output mem_action_e                      ent_mem_action,
	output logic [IMM_WIDTH-1:0]             ent_immediate,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] ent_rs_phys,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] ent_rt_phys,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] ent_rd_phys,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] ent_old_rd_phys,
	output logic                             ent_has_rd
);

	logic needs_alloc;
	logic accept;

	// Writes to register 0 are dropped, no tag taken
	assign needs_alloc = uses_rw && (rw_addr != '0);

	assign dec_ready = !full && (!needs_alloc || !empty);
	assign accept    = dec_valid && dec_ready;

	// ========================================
	// Allocation and map update
	// ========================================
	assign alloc     = accept && needs_alloc;
	assign map_we    = alloc;
	assign map_waddr = rw_addr;
	assign map_wtag  = alloc_tag;

	// Queue entry
	assign push            = accept;
	assign ent_alu_op      = dec_alu_op;
	assign ent_mem_action  = dec_mem_action;
	assign ent_immediate   = dec_immediate;
	assign ent_rs_phys     = uses_rs ? rs_tag : '0;     // Unused source reads as tag 0
	assign ent_rt_phys     = uses_rt ? rt_tag : '0;
	assign ent_rd_phys     = needs_alloc ? alloc_tag : '0;
	assign ent_old_rd_phys = needs_alloc ? old_tag : '0;  // Freed when this entry retires
	assign ent_has_rd      = needs_alloc;

endmodule

// ==== verilog/rename_unit.sv ====
// Register rename unit top level: rename stage, map table, free list and instruction queue

`timescale 1ns/1ps

module rename_unit import rename_pkg::*; #(
	parameter int NUM_ARCH_REGS    = 32,
	parameter int NUM_PHYS_REGS    = 64,
	parameter int INSTR_QUEUE_SIZE = 16
) (
	input  logic                             clk,
	input  logic                             rst_n,
	// Decoder
	input  logic                             dec_valid,
	output logic                             dec_ready,
	input  alu_op_e                          dec_alu_op,
	input  mem_action_e                      dec_mem_action,
	input  logic [IMM_WIDTH-1:0]             dec_immediate,
	input  logic                             uses_rs,
	input  logic [$clog2(NUM_ARCH_REGS)-1:0] rs_addr,
	input  logic                             uses_rt,
	input  logic [$clog2(NUM_ARCH_REGS)-1:0] rt_addr,
	input  logic                             uses_rw,
	input  logic [$clog2(NUM_ARCH_REGS)-1:0] rw_addr,
	// Renamed output
	output logic                             iq_valid,
	input  logic                             iq_ready,
	output alu_op_e                          iq_alu_op,
	output mem_action_e                      iq_mem_action,
	output logic [IMM_WIDTH-1:0]             iq_immediate,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] iq_rs_phys,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] iq_rt_phys,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] iq_rd_phys,
	output logic [$clog2(NUM_PHYS_REGS)-1:0] iq_old_rd_phys,
	output logic                             iq_has_rd
);

	localparam int ARCH_W = $clog2(NUM_ARCH_REGS);
	localparam int TAG_W  = $clog2(NUM_PHYS_REGS);

	// Map table
	logic [TAG_W-1:0]  rs_tag, rt_tag, old_tag;
	logic              map_we;
	logic [ARCH_W-1:0] map_waddr;
	logic [TAG_W-1:0]  map_wtag;
	// Free list
	logic              alloc, empty, release_en;
	logic [TAG_W-1:0]  alloc_tag, release_tag;
	// Queue entry
	logic              full, push, ent_has_rd;
	alu_op_e           ent_alu_op;
	mem_action_e       ent_mem_action;
	logic [IMM_WIDTH-1:0] ent_immediate;
	logic [TAG_W-1:0]  ent_rs_phys, ent_rt_phys, ent_rd_phys, ent_old_rd_phys;

	rename_stage #(.NUM_ARCH_REGS(NUM_ARCH_REGS), .NUM_PHYS_REGS(NUM_PHYS_REGS)) u_stage (
		.dec_valid, .dec_ready, .dec_alu_op, .dec_mem_action, .dec_immediate,
		.uses_rs, .uses_rt, .uses_rw, .rw_addr,
		.rs_tag, .rt_tag, .old_tag, .map_we, .map_waddr, .map_wtag,
		.empty, .alloc, .alloc_tag,
		.full, .push, .ent_alu_op, .ent_mem_action, .ent_immediate,
		.ent_rs_phys, .ent_rt_phys, .ent_rd_phys, .ent_old_rd_phys, .ent_has_rd
	);

	rename_map #(.NUM_ARCH_REGS(NUM_ARCH_REGS), .NUM_PHYS_REGS(NUM_PHYS_REGS)) u_map (
		.clk, .rst_n, .rs_addr, .rt_addr, .rw_addr,
		.rs_tag, .rt_tag, .old_tag, .map_we, .map_waddr, .map_wtag
	);

	free_list #(.NUM_ARCH_REGS(NUM_ARCH_REGS), .NUM_PHYS_REGS(NUM_PHYS_REGS)) u_free (
		.clk, .rst_n, .alloc, .alloc_tag, .release_en, .release_tag, .empty
	);

	// Queue head is the retirement point
	instr_queue #(.NUM_PHYS_REGS(NUM_PHYS_REGS), .INSTR_QUEUE_SIZE(INSTR_QUEUE_SIZE)) u_iq (
		.clk, .rst_n, .push, .ent_alu_op, .ent_mem_action, .ent_immediate,
		.ent_rs_phys, .ent_rt_phys, .ent_rd_phys, .ent_old_rd_phys, .ent_has_rd,
		.full, .iq_valid, .iq_ready, .iq_alu_op, .iq_mem_action, .iq_immediate,
		.iq_rs_phys, .iq_rt_phys, .iq_rd_phys, .iq_old_rd_phys, .iq_has_rd,
		.release_en, .release_tag
	);

endmodule
